//--- filelist.f
verilog/axi_bus_pkg.sv
verilog/addr_map_pkg.sv
verilog/read_route_if.sv
verilog/ar_decoder.sv
verilog/route_fifo.sv
verilog/r_return_mux.sv
verilog/axi_read_xbar.sv
test/tb_clock_gen.sv
test/tb_axi_read_xbar.sv

//--- test/tb_axi_read_xbar.sv
module tb_axi_read_xbar;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NSLV        = addr_map_pkg::NUM_SLAVES;
    localparam int TOTAL_READS = 4 + 8 + 2 + 5 + 60;         // all five tests
    localparam int CYCLE_LIMIT = 40 * TOTAL_READS + 200;
    localparam axi_bus_pkg::resp_t SLVERR = 2'b10;

    logic                                clk;
    logic                                reset_n;
    axi_bus_pkg::addr_t                  m_araddr_i;
    axi_bus_pkg::prot_t                  m_arprot_i;
    logic                                m_arvalid_i;
    logic                                m_arready_o;
    axi_bus_pkg::data_t                  m_rdata_o;
    axi_bus_pkg::resp_t                  m_rresp_o;
    logic                                m_rvalid_o;
    logic                                m_rready_i;
    axi_bus_pkg::addr_t [NSLV-1:0]       s_araddr_o;
    axi_bus_pkg::prot_t [NSLV-1:0]       s_arprot_o;
    logic [NSLV-1:0]                     s_arvalid_o;
    logic [NSLV-1:0]                     s_arready_i;
    axi_bus_pkg::data_t [NSLV-1:0]       s_rdata_i;
    axi_bus_pkg::resp_t [NSLV-1:0]       s_rresp_i;
    logic [NSLV-1:0]                     s_rvalid_i;
    logic [NSLV-1:0]                     s_rready_o;

    logic [15:0]        lfsr_state = 16'd29;
    int                 err_count = 0;
    int                 check_count = 0;
    int                 reads_issued = 0;
    int                 reads_done = 0;
    int                 cycle_count = 0;
    int                 errs_before;
    logic               stream_done;
    axi_bus_pkg::data_t exp_data_q [$];                     // one entry per accepted read
    axi_bus_pkg::resp_t exp_resp_q [$];
    addr_map_pkg::slv_idx_t exp_idx_q [$];                  // slave owing each beat

    // slave model state
    int                 ar_wait [NSLV];
    int                 r_wait [NSLV];
    int                 pend_cnt [NSLV];
    axi_bus_pkg::addr_t pend_addr [NSLV][8];
    axi_bus_pkg::addr_t ar_addr [NSLV];
    logic [NSLV-1:0]    ar_fire;
    logic [NSLV-1:0]    ar_seen;
    logic [NSLV-1:0]    r_fire;

    tb_clock_gen u_clock_gen (.clk(clk), .reset_n(reset_n));

    axi_read_xbar UUT (.*);

    ////////////////////
    // helpers
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // returns 0 for an address in the hole
    function automatic logic expected_read(input axi_bus_pkg::addr_t addr,
                                           output addr_map_pkg::slv_idx_t idx,
                                           output axi_bus_pkg::data_t data,
                                           output axi_bus_pkg::resp_t resp);
        logic mapped;
        mapped = 1'b0;
        idx    = '0;
        data   = '0;
        resp   = axi_bus_pkg::RESP_OKAY;
        for (int s = 0; s < NSLV; s++) begin
            if (addr >= addr_map_pkg::REGION_BASE[s] && addr <= addr_map_pkg::REGION_LAST[s]) begin
                mapped = 1'b1;
                idx    = addr_map_pkg::slv_idx_t'(s);
                data   = addr ^ (axi_bus_pkg::data_t'(s) * 32'h1111_1111);
                resp   = (s == 3) ? SLVERR : axi_bus_pkg::RESP_OKAY;
            end
        end
        return mapped;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        err_count++;
        $display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp_val, got_val);
    endtask

    task automatic report_error(input string what);
        err_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_at_start);
        end
    endtask

    // starts and ends just after a rising edge
    task automatic issue_read(input axi_bus_pkg::addr_t addr, input axi_bus_pkg::prot_t prot);
        logic accepted;
        m_araddr_i  = addr;
        m_arprot_i  = prot;
        m_arvalid_i = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = m_arready_o;
            @(posedge clk);
            #1;
        end
        m_arvalid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (reads_done != reads_issued) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic axi_bus_pkg::addr_t slave_addr(input int s, input logic [31:0] offset);
        return addr_map_pkg::REGION_BASE[s] + (offset & 32'h00FF_FFFF);
    endfunction

    ////////////////////
    // slave models
    ////////////////////

    initial begin : slave_models
        s_arready_i = '0;
        s_rvalid_i  = '0;
        s_rdata_i   = '0;
        s_rresp_i   = '0;
        for (int i = 0; i < NSLV; i++) begin
            ar_wait[i]  = rand_bits(2);           // 0..3
            r_wait[i]   = rand_bits(3) % 6;       // 0..5
            pend_cnt[i] = 0;
            s_arready_i[i] = (ar_wait[i] == 0);
        end
        forever begin
            @(negedge clk);                       // values that the next edge sees
            ar_fire = s_arvalid_o & s_arready_i;
            ar_seen = s_arvalid_o;
            r_fire  = s_rvalid_i & s_rready_o;
            for (int i = 0; i < NSLV; i++) begin
                ar_addr[i] = s_araddr_o[i];
            end
            @(posedge clk);
            #1;
            for (int i = 0; i < NSLV; i++) begin
                if (r_fire[i]) begin
                    for (int k = 0; k < 7; k++) begin
                        pend_addr[i][k] = pend_addr[i][k+1];
                    end
                    pend_cnt[i]--;
                    r_wait[i] = rand_bits(3) % 6;
                end else if (pend_cnt[i] != 0 && r_wait[i] != 0) begin
                    r_wait[i]--;
                end
                if (ar_fire[i]) begin
                    pend_addr[i][pend_cnt[i]] = ar_addr[i];
                    pend_cnt[i]++;
                    ar_wait[i] = rand_bits(2);
                end else if (ar_seen[i] && ar_wait[i] != 0) begin
                    ar_wait[i]--;
                end
                s_arready_i[i] = (ar_wait[i] == 0);
                s_rvalid_i[i]  = (pend_cnt[i] != 0) && (r_wait[i] == 0);
                s_rdata_i[i]   = s_rvalid_i[i] ?
                                 pend_addr[i][0] ^ (axi_bus_pkg::data_t'(i) * 32'h1111_1111) : '0;
                s_rresp_i[i]   = (i == 3) ? SLVERR : axi_bus_pkg::RESP_OKAY;
            end
        end
    end

    ////////////////////
    // checker
    ////////////////////

    always @(negedge clk) begin : response_checker
        logic                   mapped;
        addr_map_pkg::slv_idx_t exp_idx;
        axi_bus_pkg::data_t     exp_data;
        axi_bus_pkg::resp_t     exp_resp;
        logic [NSLV-1:0]        exp_arvalid;
        logic [NSLV-1:0]        exp_rready;
        // only the slave owing the oldest beat sees the master's ready
        if (reset_n) begin
            exp_rready = '0;
            if (exp_idx_q.size() != 0 && m_rready_i) begin
                exp_rready[exp_idx_q[0]] = 1'b1;
            end
            assert (s_rready_o == exp_rready)
            else report_mismatch("s_rready_o", exp_rready, s_rready_o);
        end
        if (reset_n && m_arvalid_i) begin
            mapped = expected_read(m_araddr_i, exp_idx, exp_data, exp_resp);
            check_count++;
            if (!mapped) begin
                assert (!m_arready_o && s_arvalid_o == '0)
                else report_error("unmapped read was accepted or forwarded to a slave");
            end else begin
                // no slave sees a request while four reads are outstanding
                exp_arvalid = '0;
                if (exp_idx_q.size() < addr_map_pkg::ROUTE_DEPTH) begin
                    exp_arvalid[exp_idx] = 1'b1;
                end
                assert (s_arvalid_o == exp_arvalid)
                else report_mismatch("s_arvalid_o", exp_arvalid, s_arvalid_o);
                if (m_arready_o) begin
                    assert (s_araddr_o[exp_idx] == m_araddr_i)
                    else report_mismatch("s_araddr_o", m_araddr_i, s_araddr_o[exp_idx]);
                    assert (s_arprot_o[exp_idx] == m_arprot_i)
                    else report_mismatch("s_arprot_o", m_arprot_i, s_arprot_o[exp_idx]);
                    exp_data_q.push_back(exp_data);
                    exp_resp_q.push_back(exp_resp);
                    exp_idx_q.push_back(exp_idx);
                    reads_issued++;
                end
            end
        end
        if (reset_n && m_rvalid_o && m_rready_i) begin
            reads_done++;
            check_count++;
            assert (exp_data_q.size() != 0)
            else report_error("R beat returned with no read outstanding");
            if (exp_data_q.size() != 0) begin
                exp_data = exp_data_q.pop_front();
                exp_resp = exp_resp_q.pop_front();
                exp_idx  = exp_idx_q.pop_front();
                assert (m_rdata_o == exp_data)
                else report_mismatch("m_rdata_o", exp_data, m_rdata_o);
                assert (m_rresp_o == exp_resp)
                else report_mismatch("m_rresp_o", exp_resp, m_rresp_o);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d reads returned",
                     cycle_count, reads_done, reads_issued);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        m_araddr_i  = '0;
        m_arprot_i  = '0;
        m_arvalid_i = 1'b0;
        m_rready_i  = 1'b0;
        stream_done = 1'b0;
        @(posedge reset_n);
        @(posedge clk);
        #1;
        m_rready_i = 1'b1;

        errs_before = err_count;
        for (int s = 0; s < NSLV; s++) begin
            issue_read(slave_addr(s, 32'h1230 * (s + 1)), axi_bus_pkg::prot_t'(s + 1));
            wait_drain();
        end
        finish_test("1 single reads", errs_before);

        errs_before = err_count;
        for (int n = 0; n < 8; n++) begin
            issue_read(slave_addr((3 * n + 3) % NSLV, rand_bits(16)),
                       axi_bus_pkg::prot_t'(rand_bits(3)));
        end
        wait_drain();
        finish_test("2 ordering", errs_before);

        // 0500_0000 falls in the hole
        errs_before = err_count;
        m_araddr_i  = 32'h0500_0000;
        m_arprot_i  = '0;
        m_arvalid_i = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        m_arvalid_i = 1'b0;
        issue_read(slave_addr(1, 32'h40), 3'd2);
        wait_drain();
        finish_test("3 unmapped", errs_before);

        errs_before = err_count;
        m_rready_i  = 1'b0;
        for (int s = 0; s < NSLV; s++) begin
            issue_read(slave_addr(s, 32'h800 + s), '0);
        end
        fork
            begin
                issue_read(slave_addr(2, 32'h900), 3'd1);
                assert (reads_done >= 1)
                else report_error("fifth read accepted before any R handshake");
            end
            begin
                repeat (10) begin
                    @(negedge clk);
                    assert (!m_arready_o)
                    else report_error("fifth read accepted while route FIFO was full");
                end
                @(posedge clk);
                #1;
                m_rready_i = 1'b1;
            end
        join
        wait_drain();
        finish_test("4 back-pressure", errs_before);

        errs_before = err_count;
        fork
            begin
                for (int n = 0; n < 60; n++) begin
                    issue_read(slave_addr(rand_bits(2), rand_bits(24)),
                               axi_bus_pkg::prot_t'(rand_bits(3)));
                end
                stream_done = 1'b1;
            end
            while (!stream_done) begin
                @(posedge clk);
                #1;
                m_rready_i = (rand_bits(2) != 0);   // ready about 3 cycles in 4
            end
        join
        m_rready_i = 1'b1;
        wait_drain();
        finish_test("5 random stream", errs_before);

        $display("%0d checks, %0d errors, %0d reads returned", check_count, err_count, reads_done);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

//--- verilog/addr_map_pkg.sv
package addr_map_pkg;

    ////////////////////
    // slave set
    ////////////////////

    localparam int NUM_SLAVES = 4;
    localparam int SLV_IDX_W  = 2;   // enough to number every slave

    typedef logic [SLV_IDX_W-1:0] slv_idx_t;

    ////////////////////
    // address regions
    ////////////////////

    // inclusive range per slave
    // 0300_0000 .. 9FFF_FFFF is left unmapped
    localparam axi_bus_pkg::addr_t REGION_BASE [NUM_SLAVES] = '{
        32'h0000_0000,   // slave 0
        32'h0100_0000,   // slave 1
        32'h0200_0000,   // slave 2
        32'hA000_0000    // slave 3 in the high region
    };

    localparam axi_bus_pkg::addr_t REGION_LAST [NUM_SLAVES] = '{
        32'h00FF_FFFF,
        32'h01FF_FFFF,
        32'h02FF_FFFF,
        32'hAFFF_FFFF
    };

    // outstanding read tracking
    localparam int ROUTE_DEPTH = 4;
    localparam int ROUTE_PTR_W = 2;

endpackage

//--- verilog/ar_decoder.sv
module ar_decoder (
    // master AR
    input  axi_bus_pkg::addr_t                                m_araddr_i,
    input  axi_bus_pkg::prot_t                                m_arprot_i,
    input  logic                                              m_arvalid_i,
    output logic                                              m_arready_o,

    // slave AR
    output axi_bus_pkg::addr_t [addr_map_pkg::NUM_SLAVES-1:0] s_araddr_o,
    output axi_bus_pkg::prot_t [addr_map_pkg::NUM_SLAVES-1:0] s_arprot_o,
    output logic [addr_map_pkg::NUM_SLAVES-1:0]               s_arvalid_o,
    input  logic [addr_map_pkg::NUM_SLAVES-1:0]               s_arready_i,

    read_route_if.decoder                                     route
);

    logic [addr_map_pkg::NUM_SLAVES-1:0] hit;      // one-hot region match
    logic [addr_map_pkg::NUM_SLAVES-1:0] sel;      // match with a live request
    addr_map_pkg::slv_idx_t              hit_idx;

    ////////////////////
    // region compare
    ////////////////////

    always_comb begin
        for (int i = 0; i < addr_map_pkg::NUM_SLAVES; i++) begin
            hit[i] = (m_araddr_i >= addr_map_pkg::REGION_BASE[i]) &&
                     (m_araddr_i <= addr_map_pkg::REGION_LAST[i]);
        end
    end

    assign sel = hit & {addr_map_pkg::NUM_SLAVES{m_arvalid_i}};

    // regions never overlap, so at most one bit is set
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < addr_map_pkg::NUM_SLAVES; i++) begin
            if (hit[i]) begin
                hit_idx = addr_map_pkg::slv_idx_t'(i);
            end
        end
    end

    ////////////////////
    // fan-out to slaves
    ////////////////////

    always_comb begin
        for (int i = 0; i < addr_map_pkg::NUM_SLAVES; i++) begin
            s_araddr_o[i]  = sel[i] ? m_araddr_i : '0;
            s_arprot_o[i]  = sel[i] ? m_arprot_i : '0;
            s_arvalid_o[i] = sel[i] & ~route.full;  // held off while no room to track it
        end
    end

    // unmapped address leaves sel empty, so arready stays low
    assign m_arready_o = (|(sel & s_arready_i)) & ~route.full;

    assign route.push     = m_arvalid_i & m_arready_o;
    assign route.push_idx = hit_idx;

endmodule

//--- verilog/axi_bus_pkg.sv
package axi_bus_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int PROT_W = 3;   // AxPROT
    localparam int RESP_W = 2;   // xRESP

    ////////////////////
    // channel field types
    ////////////////////

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PROT_W-1:0] prot_t;
    typedef logic [RESP_W-1:0] resp_t;

    // AXI-Lite response codes
    localparam resp_t RESP_OKAY = 2'b00;

endpackage

//--- verilog/axi_read_xbar.sv
module axi_read_xbar (
    input  logic                                              clk,
    input  logic                                              reset_n,

    ////////////////////
    // master side
    ////////////////////

    input  axi_bus_pkg::addr_t                                m_araddr_i,
    input  axi_bus_pkg::prot_t                                m_arprot_i,
    input  logic                                              m_arvalid_i,
    output logic                                              m_arready_o,

    output axi_bus_pkg::data_t                                m_rdata_o,
    output axi_bus_pkg::resp_t                                m_rresp_o,
    output logic                                              m_rvalid_o,
    input  logic                                              m_rready_i,

    ////////////////////
    // slave side
    ////////////////////

    output axi_bus_pkg::addr_t [addr_map_pkg::NUM_SLAVES-1:0] s_araddr_o,
    output axi_bus_pkg::prot_t [addr_map_pkg::NUM_SLAVES-1:0] s_arprot_o,
    output logic [addr_map_pkg::NUM_SLAVES-1:0]               s_arvalid_o,
    input  logic [addr_map_pkg::NUM_SLAVES-1:0]               s_arready_i,

    input  axi_bus_pkg::data_t [addr_map_pkg::NUM_SLAVES-1:0] s_rdata_i,
    input  axi_bus_pkg::resp_t [addr_map_pkg::NUM_SLAVES-1:0] s_rresp_i,
    input  logic [addr_map_pkg::NUM_SLAVES-1:0]               s_rvalid_i,
    output logic [addr_map_pkg::NUM_SLAVES-1:0]               s_rready_o
);

    // route entries from AR decode to R return
    read_route_if route_bus ();

    ar_decoder u_ar_decoder (
        .m_araddr_i  (m_araddr_i),
        .m_arprot_i  (m_arprot_i),
        .m_arvalid_i (m_arvalid_i),
        .m_arready_o (m_arready_o),
        .s_araddr_o  (s_araddr_o),
        .s_arprot_o  (s_arprot_o),
        .s_arvalid_o (s_arvalid_o),
        .s_arready_i (s_arready_i),
        .route       (route_bus.decoder)
    );

    // keeps read data in request order
    route_fifo u_route_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .route   (route_bus.fifo)
    );

    r_return_mux u_r_return_mux (
        .m_rdata_o  (m_rdata_o),
        .m_rresp_o  (m_rresp_o),
        .m_rvalid_o (m_rvalid_o),
        .m_rready_i (m_rready_i),
        .s_rdata_i  (s_rdata_i),
        .s_rresp_i  (s_rresp_i),
        .s_rvalid_i (s_rvalid_i),
        .s_rready_o (s_rready_o),
        .route      (route_bus.returner)
    );

endmodule

//--- verilog/r_return_mux.sv
module r_return_mux (
    // master R
    output axi_bus_pkg::data_t                                m_rdata_o,
    output axi_bus_pkg::resp_t                                m_rresp_o,
    output logic                                              m_rvalid_o,
    input  logic                                              m_rready_i,

    // slave R
    input  axi_bus_pkg::data_t [addr_map_pkg::NUM_SLAVES-1:0] s_rdata_i,
    input  axi_bus_pkg::resp_t [addr_map_pkg::NUM_SLAVES-1:0] s_rresp_i,
    input  logic [addr_map_pkg::NUM_SLAVES-1:0]               s_rvalid_i,
    output logic [addr_map_pkg::NUM_SLAVES-1:0]               s_rready_o,

    read_route_if.returner                                    route
);

    logic [addr_map_pkg::NUM_SLAVES-1:0] head_sel;  // one-hot owner of the next beat

    always_comb begin
        for (int i = 0; i < addr_map_pkg::NUM_SLAVES; i++) begin
            head_sel[i] = route.head_valid &&
                          (route.head_idx == addr_map_pkg::slv_idx_t'(i));
        end
    end

    ////////////////////
    // slave to master
    ////////////////////

    always_comb begin
        m_rvalid_o = 1'b0;
        m_rdata_o  = '0;
        m_rresp_o  = axi_bus_pkg::RESP_OKAY;   // idle value
        for (int i = 0; i < addr_map_pkg::NUM_SLAVES; i++) begin
            if (head_sel[i]) begin
                m_rvalid_o = s_rvalid_i[i];
                m_rdata_o  = s_rdata_i[i];
                m_rresp_o  = s_rresp_i[i];
            end
        end
    end

    // only the head slave sees the master's ready
    assign s_rready_o = head_sel & {addr_map_pkg::NUM_SLAVES{m_rready_i}};

    assign route.pop = m_rvalid_o & m_rready_i;

endmodule

//--- verilog/read_route_if.sv
interface read_route_if;

    logic                   push;        // AR handshake done
    addr_map_pkg::slv_idx_t push_idx;    // slave that took the request
    logic                   full;
    logic                   head_valid;  // at least one read outstanding
    addr_map_pkg::slv_idx_t head_idx;    // slave owing the oldest R beat
    logic                   pop;         // R handshake done

    modport decoder (
        output push,
        output push_idx,
        input  full
    );

    modport fifo (
        input  push,
        input  push_idx,
        input  pop,
        output full,
        output head_valid,
        output head_idx
    );

    modport returner (
        input  head_valid,
        input  head_idx,
        output pop
    );

endinterface

//--- verilog/route_fifo.sv
module route_fifo (
    input  logic       clk,
    input  logic       reset_n,
    read_route_if.fifo route
);

    logic [addr_map_pkg::ROUTE_PTR_W-1:0] wr_ptr;
    logic [addr_map_pkg::ROUTE_PTR_W-1:0] rd_ptr;
    logic [addr_map_pkg::ROUTE_PTR_W-1:0] wr_ptr_next;
    logic [addr_map_pkg::ROUTE_PTR_W-1:0] rd_ptr_next;
    logic                                 full;
    logic                                 empty;
    logic                                 full_next;
    logic                                 empty_next;
    logic                                 do_push;
    logic                                 do_pop;

    // slave index of each outstanding read with the oldest at rd_ptr
    addr_map_pkg::slv_idx_t mem [addr_map_pkg::ROUTE_DEPTH];

    assign do_push = route.push & ~full;
    assign do_pop  = route.pop & ~empty;

    ////////////////////
    // pointer and flag update
    ////////////////////

    always_comb begin
        wr_ptr_next = wr_ptr;
        rd_ptr_next = rd_ptr;
        full_next   = full;
        empty_next  = empty;

        case ({do_push, do_pop})
            2'b10: begin   // push only
                wr_ptr_next = wr_ptr + 1'b1;
                empty_next  = 1'b0;
                full_next   = (wr_ptr_next == rd_ptr);
            end
            2'b01: begin   // pop only
                rd_ptr_next = rd_ptr + 1'b1;
                full_next   = 1'b0;
                empty_next  = (rd_ptr_next == wr_ptr);
            end
            2'b11: begin   // count unchanged
                wr_ptr_next = wr_ptr + 1'b1;
                rd_ptr_next = rd_ptr + 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            wr_ptr <= wr_ptr_next;
            rd_ptr <= rd_ptr_next;
            full   <= full_next;
            empty  <= empty_next;
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= route.push_idx;
        end
    end

    assign route.full       = full;
    assign route.head_valid = ~empty;
    assign route.head_idx   = mem[rd_ptr];  // meaningful only with head_valid

endmodule
